//--- include/core_cfg.svh
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// data path and pc width, one word
`define CFG_XLEN 32

// register file addressing
`define CFG_REG_AW 5
`define CFG_NREGS 32

// first fetch address, in words
`define CFG_RESET_PC 32'h0000_0000

`endif

//--- hdl/core_pkg.sv
`include "core_cfg.svh"

package core_pkg;

    // rv32i major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    // alu class, execute resolves FUNCT from funct3 and bit 30
    typedef enum logic [1:0] {
        ALU_ADD    = 2'd0,
        ALU_BRANCH = 2'd1,
        ALU_FUNCT  = 2'd2,
        ALU_PASS_B = 2'd3
    } alu_op_e;

    typedef enum logic [1:0] {
        JUMP_NONE   = 2'd0,
        JUMP_BRANCH = 2'd1,
        JUMP_JAL    = 2'd2,
        JUMP_JALR   = 2'd3
    } jump_e;

    // write-back source select
    typedef enum logic [1:0] {
        WR_ALU     = 2'd0,
        WR_MEM     = 2'd1,
        WR_PC_PLUS = 2'd2,
        WR_IMM     = 2'd3
    } wr_mux_e;

    // forward[0] marks an rs1 read, forward[1] an rs2 read
    typedef struct packed {
        alu_op_e    alu_op;
        jump_e      jump;
        logic [1:0] forward;
        wr_mux_e    wr_mux;
        logic       uart;
        logic       dmem;
        logic       csr_we;
        logic       reg_we;
        logic [2:0] load;
    } ctrl_t;

    typedef struct packed {
        logic                   valid;
        ctrl_t                  ctrl;
        logic [2:0]             funct3;
        logic                   alu30;
        logic [`CFG_XLEN-1:0]   pc;
        logic [`CFG_XLEN-1:0]   pc_plus;
        logic [`CFG_XLEN-1:0]   imm;
        logic [`CFG_REG_AW-1:0] rd;
        logic [`CFG_REG_AW-1:0] rs1;
        logic [`CFG_REG_AW-1:0] rs2;
        logic [`CFG_XLEN-1:0]   reg1_data;
        logic [`CFG_XLEN-1:0]   reg2_data;
    } id_ex_t;

endpackage

//--- hdl/pc_gen.sv
`timescale 1ns/10ps
`include "core_cfg.svh"

module pc_gen (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 step_i,
    input  logic                 redirect_i,
    input  logic [`CFG_XLEN-1:0] target_i,
    output logic [`CFG_XLEN-1:0] pc_o
);

    logic [`CFG_XLEN-1:0] pc_q;

    // redirect wins over the sequential step
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc_q <= `CFG_RESET_PC;
        end else if (redirect_i) begin
            pc_q <= target_i;
        end else if (step_i) begin
            pc_q <= pc_q + 1'b1;
        end
    end

    assign pc_o = pc_q;

endmodule

//--- hdl/regfile.sv
`timescale 1ns/10ps
`include "core_cfg.svh"

module regfile (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   we_i,
    input  logic [`CFG_REG_AW-1:0] waddr_i,
    input  logic [`CFG_XLEN-1:0]   wdata_i,
    input  logic [`CFG_REG_AW-1:0] raddr1_i,
    input  logic [`CFG_REG_AW-1:0] raddr2_i,
    output logic [`CFG_XLEN-1:0]   rdata1_o,
    output logic [`CFG_XLEN-1:0]   rdata2_o
);

    logic [`CFG_XLEN-1:0] regs [`CFG_NREGS];
    logic                 wr_ok;

    // x0 is never written
    assign wr_ok = we_i && (waddr_i != '0);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `CFG_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_ok) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // same cycle write is visible to the reader
    assign rdata1_o = (raddr1_i == '0) ? '0 :
                      (wr_ok && waddr_i == raddr1_i) ? wdata_i : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 :
                      (wr_ok && waddr_i == raddr2_i) ? wdata_i : regs[raddr2_i];

endmodule

//--- hdl/control_unit.sv
`timescale 1ns/10ps

module control_unit (
    input  logic [6:0]      opcode_i,
    input  logic [2:0]      funct3_i,
    output core_pkg::ctrl_t ctrl_o
);

    import core_pkg::*;

    always_comb begin
        // unknown opcodes leave everything at zero
        ctrl_o = '0;
        case (opcode_i)
            OPC_LUI: begin
                ctrl_o.alu_op = ALU_PASS_B;
                ctrl_o.wr_mux = WR_IMM;
                ctrl_o.reg_we = 1'b1;
            end
            OPC_AUIPC: begin
                ctrl_o.alu_op = ALU_ADD;
                ctrl_o.wr_mux = WR_ALU;
                ctrl_o.reg_we = 1'b1;
            end
            OPC_JAL: begin
                ctrl_o.jump   = JUMP_JAL;
                ctrl_o.wr_mux = WR_PC_PLUS;
                ctrl_o.reg_we = 1'b1;
            end
            OPC_JALR: begin
                ctrl_o.jump    = JUMP_JALR;
                ctrl_o.forward = 2'b01;
                ctrl_o.wr_mux  = WR_PC_PLUS;
                ctrl_o.reg_we  = 1'b1;
            end
            OPC_BRANCH: begin
                ctrl_o.jump    = JUMP_BRANCH;
                ctrl_o.alu_op  = ALU_BRANCH;
                ctrl_o.forward = 2'b11;
            end
            OPC_LOAD: begin
                ctrl_o.forward = 2'b01;
                ctrl_o.dmem    = 1'b1;
                ctrl_o.wr_mux  = WR_MEM;
                ctrl_o.reg_we  = 1'b1;
                ctrl_o.load    = funct3_i;
            end
            OPC_STORE: begin
                ctrl_o.forward = 2'b11;
                ctrl_o.dmem    = 1'b1;
            end
            OPC_OP_IMM: begin
                ctrl_o.alu_op  = ALU_FUNCT;
                ctrl_o.forward = 2'b01;
                ctrl_o.reg_we  = 1'b1;
            end
            OPC_OP: begin
                ctrl_o.alu_op  = ALU_FUNCT;
                ctrl_o.forward = 2'b11;
                ctrl_o.reg_we  = 1'b1;
            end
            OPC_SYSTEM: begin
                // csr ops write rd, ecall goes to the console
                ctrl_o.csr_we  = (funct3_i != 3'b000);
                ctrl_o.reg_we  = (funct3_i != 3'b000);
                ctrl_o.forward = {1'b0, funct3_i != 3'b000};
                ctrl_o.uart    = (funct3_i == 3'b000);
            end
            default: begin
                ctrl_o = '0;
            end
        endcase
    end

endmodule

//--- hdl/imm_gen.sv
`timescale 1ns/10ps
`include "core_cfg.svh"

module imm_gen (
    input  logic [`CFG_XLEN-1:0] inst_i,
    output logic [`CFG_XLEN-1:0] imm_o,
    output logic [`CFG_XLEN-1:0] offset_o
);

    import core_pkg::*;

    logic [`CFG_XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_u = {inst_i[31:12], 12'b0};
    assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

    always_comb begin
        case (inst_i[6:0])
            OPC_JALR, OPC_LOAD, OPC_OP_IMM, OPC_SYSTEM: imm_o = imm_i;
            OPC_STORE:                                  imm_o = imm_s;
            OPC_BRANCH:                                 imm_o = imm_b;
            OPC_LUI, OPC_AUIPC:                         imm_o = imm_u;
            OPC_JAL:                                    imm_o = imm_j;
            default:                                    imm_o = '0;
        endcase
    end

    // byte offset for the pc-relative targets
    assign offset_o = (inst_i[6:0] == OPC_JAL) ? imm_j : imm_b;

endmodule

//--- hdl/id.sv
`timescale 1ns/10ps
`include "core_cfg.svh"

module id (
    input  logic [`CFG_XLEN-1:0]   inst_i,
    input  logic                   inst_valid_i,
    input  logic [`CFG_XLEN-1:0]   pc_i,
    input  logic [`CFG_XLEN-1:0]   reg1_data_i,
    input  logic [`CFG_XLEN-1:0]   reg2_data_i,
    output logic [`CFG_REG_AW-1:0] reg1_addr_o,
    output logic [`CFG_REG_AW-1:0] reg2_addr_o,
    output logic                   redirect_o,
    output logic [`CFG_XLEN-1:0]   redirect_pc_o,
    output core_pkg::id_ex_t       id_ex_d_o
);

    import core_pkg::*;

    ctrl_t                ctrl;
    logic [2:0]           funct3;
    logic [`CFG_XLEN-1:0] imm;
    logic [`CFG_XLEN-1:0] offset;
    logic [`CFG_XLEN-1:0] jalr_sum;
    logic                 taken;

    assign funct3      = inst_i[14:12];
    assign reg1_addr_o = inst_i[19:15];
    assign reg2_addr_o = inst_i[24:20];

    control_unit i_control_unit (
        .opcode_i (inst_i[6:0]),
        .funct3_i (funct3),
        .ctrl_o   (ctrl)
    );

    imm_gen i_imm_gen (
        .inst_i   (inst_i),
        .imm_o    (imm),
        .offset_o (offset)
    );

    // branch compare, signedness from funct3
    always_comb begin
        case (funct3)
            3'b000:  taken = (reg1_data_i == reg2_data_i);
            3'b001:  taken = (reg1_data_i != reg2_data_i);
            3'b100:  taken = ($signed(reg1_data_i) < $signed(reg2_data_i));
            3'b101:  taken = ($signed(reg1_data_i) >= $signed(reg2_data_i));
            3'b110:  taken = (reg1_data_i < reg2_data_i);
            3'b111:  taken = (reg1_data_i >= reg2_data_i);
            default: taken = 1'b0;
        endcase
    end

    // pc counts words, so byte offsets drop two bits
    assign jalr_sum      = reg1_data_i + imm;
    assign redirect_pc_o = (ctrl.jump == JUMP_JALR) ? {2'b00, jalr_sum[`CFG_XLEN-1:2]} :
                           pc_i + {{2{offset[`CFG_XLEN-1]}}, offset[`CFG_XLEN-1:2]};

    assign redirect_o = inst_valid_i &&
                        ((ctrl.jump == JUMP_JAL) || (ctrl.jump == JUMP_JALR) ||
                         (ctrl.jump == JUMP_BRANCH && taken));

    always_comb begin
        id_ex_d_o           = '0;
        id_ex_d_o.valid     = inst_valid_i;
        id_ex_d_o.ctrl      = ctrl;
        id_ex_d_o.funct3    = funct3;
        id_ex_d_o.alu30     = inst_i[30];
        id_ex_d_o.pc        = pc_i;
        id_ex_d_o.pc_plus   = pc_i + 1'b1;
        id_ex_d_o.imm       = imm;
        id_ex_d_o.rd        = inst_i[11:7];
        id_ex_d_o.rs1       = reg1_addr_o;
        id_ex_d_o.rs2       = reg2_addr_o;
        id_ex_d_o.reg1_data = reg1_data_i;
        id_ex_d_o.reg2_data = reg2_data_i;
    end

endmodule

//--- hdl/id_ex.sv
`timescale 1ns/10ps

module id_ex (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  core_pkg::id_ex_t d_i,
    output core_pkg::id_ex_t q_o
);

    import core_pkg::*;

    id_ex_t q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            q <= '0;
        end else begin
            q <= d_i;
            // bubble carries no writes downstream
            if (!d_i.valid) begin
                q.ctrl <= '0;
            end
        end
    end

    assign q_o = q;

endmodule

//--- hdl/decode_top.sv
`timescale 1ns/10ps
`include "core_cfg.svh"

module decode_top (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic [`CFG_XLEN-1:0]   inst_i,
    input  logic                   inst_valid_i,
    input  logic                   wb_we_i,
    input  logic [`CFG_REG_AW-1:0] wb_addr_i,
    input  logic [`CFG_XLEN-1:0]   wb_data_i,
    output logic [`CFG_XLEN-1:0]   pc_o,
    output core_pkg::id_ex_t       id_ex_o,
    output logic                   redirect_o
);

    import core_pkg::*;

    logic [`CFG_XLEN-1:0]   redirect_pc;
    logic [`CFG_REG_AW-1:0] reg1_addr, reg2_addr;
    logic [`CFG_XLEN-1:0]   reg1_data, reg2_data;
    id_ex_t                 id_ex_d;

    pc_gen i_pc_gen (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .step_i     (inst_valid_i),
        .redirect_i (redirect_o),
        .target_i   (redirect_pc),
        .pc_o       (pc_o)
    );

    // write-back port comes straight from outside
    regfile i_regfile (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .we_i     (wb_we_i),
        .waddr_i  (wb_addr_i),
        .wdata_i  (wb_data_i),
        .raddr1_i (reg1_addr),
        .raddr2_i (reg2_addr),
        .rdata1_o (reg1_data),
        .rdata2_o (reg2_data)
    );

    id i_id (
        .inst_i        (inst_i),
        .inst_valid_i  (inst_valid_i),
        .pc_i          (pc_o),
        .reg1_data_i   (reg1_data),
        .reg2_data_i   (reg2_data),
        .reg1_addr_o   (reg1_addr),
        .reg2_addr_o   (reg2_addr),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc),
        .id_ex_d_o     (id_ex_d)
    );

    id_ex i_id_ex (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .d_i     (id_ex_d),
        .q_o     (id_ex_o)
    );

endmodule

//--- tb/tb_decode_top.sv
`timescale 1ns/10ps
`include "core_cfg.svh"

module tb_decode_top;

    import core_pkg::*;

    localparam int N_ALU       = 40;
    localparam int N_JUMP      = 16;
    localparam int N_RAND      = 200;
    // reset, idle, alu, regfile, branch, jumps, random stream, drain
    localparam int TEST_CYCLES = 3 + 3 + N_ALU + 6 + 3 * 18 + 2 * N_JUMP + N_RAND + 3;
    localparam int MAX_CYCLES  = 4 * TEST_CYCLES;

    logic                   clk;
    logic                   rst_n;
    logic [`CFG_XLEN-1:0]   inst;
    logic                   inst_valid;
    logic                   wb_we;
    logic [`CFG_REG_AW-1:0] wb_addr;
    logic [`CFG_XLEN-1:0]   wb_data;
    logic [`CFG_XLEN-1:0]   pc;
    id_ex_t                 id_ex;
    logic                   redirect;

    logic [31:0] prog   [1024];
    logic [31:0] shadow [`CFG_NREGS];
    logic [31:0] pair_a [3] = '{32'd5, 32'd3, 32'hffff_fffe};
    logic [31:0] pair_b [3] = '{32'd5, 32'hffff_fffe, 32'd3};
    logic [2:0]  conds  [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    logic [31:0] model_pc;
    id_ex_t      exp_q;
    logic        armed;
    string       test_name;
    integer      seed;
    int          cycles = 0;

    decode_top i_dut (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .inst_i       (inst),
        .inst_valid_i (inst_valid),
        .wb_we_i      (wb_we),
        .wb_addr_i    (wb_addr),
        .wb_data_i    (wb_data),
        .pc_o         (pc),
        .id_ex_o      (id_ex),
        .redirect_o   (redirect)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation failed");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Error %s %s: expected %h, actual %h", test_name, what, expected, actual);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    // random fields above the given opcode
    function automatic logic [31:0] rand_inst(input logic [6:0] opc);
        logic [31:0] r;
        r = rand_word();
        return {r[31:7], opc};
    endfunction

    function automatic logic [31:0] branch_inst(input logic [12:0] off, input logic [4:0] rs2,
                                                input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic logic [6:0] stream_opcode(input logic [2:0] sel);
        case (sel)
            3'd0:    return OPC_LOAD;
            3'd1:    return OPC_STORE;
            3'd2:    return OPC_LUI;
            3'd3:    return OPC_AUIPC;
            3'd4:    return OPC_SYSTEM;
            // fence, custom and all-zero words are not decoded
            3'd5:    return 7'b0001111;
            3'd6:    return 7'b1111111;
            default: return 7'b0000000;
        endcase
    endfunction

    // register read as decode sees it, with the same cycle write-back
    function automatic logic [31:0] read_shadow(input logic [4:0] addr, input logic we,
                                                input logic [4:0] waddr,
                                                input logic [31:0] wdata);
        if (addr == 5'd0) begin
            return 32'd0;
        end
        if (we && waddr == addr) begin
            return wdata;
        end
        return shadow[addr];
    endfunction

    function automatic id_ex_t ref_decode(input logic [31:0] word, input logic [31:0] pc_in,
                                          input logic [31:0] r1, input logic [31:0] r2,
                                          output logic [31:0] next_pc, output logic jumped);
        id_ex_t      e;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_u;
        logic [31:0] imm_j;
        logic [31:0] br_step;
        logic [31:0] jal_step;
        logic        lt_s;
        logic        lt_u;
        logic        taken;
        imm_i    = {{20{word[31]}}, word[31:20]};
        imm_s    = {{20{word[31]}}, word[31:25], word[11:7]};
        imm_b    = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
        imm_u    = {word[31:12], 12'h000};
        imm_j    = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
        // byte offsets become word steps
        br_step  = $signed(imm_b) >>> 2;
        jal_step = $signed(imm_j) >>> 2;
        lt_s     = $signed(r1) < $signed(r2);
        lt_u     = r1 < r2;
        case (word[14:12])
            3'd0:    taken = (r1 == r2);
            3'd1:    taken = (r1 != r2);
            3'd4:    taken = lt_s;
            3'd5:    taken = !lt_s;
            3'd6:    taken = lt_u;
            3'd7:    taken = !lt_u;
            default: taken = 1'b0;
        endcase
        e           = '0;
        e.valid     = 1'b1;
        e.funct3    = word[14:12];
        e.alu30     = word[30];
        e.pc        = pc_in;
        e.pc_plus   = pc_in + 32'd1;
        e.rd        = word[11:7];
        e.rs1       = word[19:15];
        e.rs2       = word[24:20];
        e.reg1_data = r1;
        e.reg2_data = r2;
        next_pc     = pc_in + 32'd1;
        jumped      = 1'b0;
        // forward bit 0 for an rs1 read, bit 1 for an rs2 read
        case (word[6:0])
            OPC_LUI: begin
                e.imm         = imm_u;
                e.ctrl.alu_op = ALU_PASS_B;
                e.ctrl.wr_mux = WR_IMM;
                e.ctrl.reg_we = 1'b1;
            end
            OPC_AUIPC: begin
                e.imm         = imm_u;
                e.ctrl.reg_we = 1'b1;
            end
            OPC_JAL: begin
                e.imm         = imm_j;
                e.ctrl.jump   = JUMP_JAL;
                e.ctrl.wr_mux = WR_PC_PLUS;
                e.ctrl.reg_we = 1'b1;
                next_pc       = pc_in + jal_step;
                jumped        = 1'b1;
            end
            OPC_JALR: begin
                e.imm          = imm_i;
                e.ctrl.jump    = JUMP_JALR;
                e.ctrl.forward = 2'b01;
                e.ctrl.wr_mux  = WR_PC_PLUS;
                e.ctrl.reg_we  = 1'b1;
                next_pc        = (r1 + imm_i) >> 2;
                jumped         = 1'b1;
            end
            OPC_BRANCH: begin
                e.imm          = imm_b;
                e.ctrl.jump    = JUMP_BRANCH;
                e.ctrl.alu_op  = ALU_BRANCH;
                e.ctrl.forward = 2'b11;
                if (taken) begin
                    next_pc = pc_in + br_step;
                    jumped  = 1'b1;
                end
            end
            OPC_LOAD: begin
                e.imm          = imm_i;
                e.ctrl.forward = 2'b01;
                e.ctrl.dmem    = 1'b1;
                e.ctrl.wr_mux  = WR_MEM;
                e.ctrl.reg_we  = 1'b1;
                e.ctrl.load    = word[14:12];
            end
            OPC_STORE: begin
                e.imm          = imm_s;
                e.ctrl.forward = 2'b11;
                e.ctrl.dmem    = 1'b1;
            end
            OPC_OP_IMM: begin
                e.imm          = imm_i;
                e.ctrl.alu_op  = ALU_FUNCT;
                e.ctrl.forward = 2'b01;
                e.ctrl.reg_we  = 1'b1;
            end
            OPC_OP: begin
                e.ctrl.alu_op  = ALU_FUNCT;
                e.ctrl.forward = 2'b11;
                e.ctrl.reg_we  = 1'b1;
            end
            OPC_SYSTEM: begin
                e.imm = imm_i;
                // csr ops read rs1 and write rd, ecall goes to the console
                if (word[14:12] != 3'd0) begin
                    e.ctrl.csr_we  = 1'b1;
                    e.ctrl.reg_we  = 1'b1;
                    e.ctrl.forward = 2'b01;
                end else begin
                    e.ctrl.uart = 1'b1;
                end
            end
            default: begin
                e.ctrl = '0;
            end
        endcase
        return e;
    endfunction

    // one cycle of stimulus plus the prediction for the next edge
    task automatic drive_cycle(input logic valid, input logic [31:0] word, input logic we,
                               input logic [4:0] waddr, input logic [31:0] wdata);
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] next_pc;
        logic        jumped;
        @(posedge clk);
        #2;
        // place the word at the fetch address, then return it
        prog[pc[9:0]] = word;
        inst          = prog[pc[9:0]];
        inst_valid    = valid;
        wb_we         = we;
        wb_addr       = waddr;
        wb_data       = wdata;
        r1 = read_shadow(word[19:15], we, waddr, wdata);
        r2 = read_shadow(word[24:20], we, waddr, wdata);
        if (valid) begin
            exp_q = ref_decode(word, model_pc, r1, r2, next_pc, jumped);
        end else begin
            exp_q   = '0;
            next_pc = model_pc;
            jumped  = 1'b0;
        end
        model_pc = next_pc;
        if (we && waddr != 5'd0) begin
            shadow[waddr] = wdata;
        end
        // redirect is decided in this cycle
        #1;
        check_value("redirect", 32'(jumped), 32'(redirect));
    endtask

    task automatic issue_inst(input logic [31:0] word);
        drive_cycle(1'b1, word, 1'b0, 5'd0, 32'd0);
    endtask

    task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
        drive_cycle(1'b0, 32'd0, 1'b1, addr, data);
    endtask

    always @(posedge clk) begin
        if (armed) begin
            #1;
            check_value("pc", model_pc, pc);
            check_value("valid", 32'(exp_q.valid), 32'(id_ex.valid));
            check_value("ctrl", 32'(exp_q.ctrl), 32'(id_ex.ctrl));
            if (exp_q.valid) begin
                check_value("funct3 and bit 30", 32'({exp_q.funct3, exp_q.alu30}),
                            32'({id_ex.funct3, id_ex.alu30}));
                check_value("pc field", exp_q.pc, id_ex.pc);
                check_value("pc_plus", exp_q.pc_plus, id_ex.pc_plus);
                check_value("imm", exp_q.imm, id_ex.imm);
                check_value("rd rs1 rs2", 32'({exp_q.rd, exp_q.rs1, exp_q.rs2}),
                            32'({id_ex.rd, id_ex.rs1, id_ex.rs2}));
                check_value("reg1_data", exp_q.reg1_data, id_ex.reg1_data);
                check_value("reg2_data", exp_q.reg2_data, id_ex.reg2_data);
            end
        end
    end

    initial begin
        logic [31:0] r;
        logic [31:0] word;
        seed        = 32'h1b59_2205;
        armed       = 1'b0;
        rst_n       = 1'b0;
        inst        = '0;
        inst_valid  = 1'b0;
        wb_we       = 1'b0;
        wb_addr     = '0;
        wb_data     = '0;
        model_pc    = `CFG_RESET_PC;
        exp_q       = '0;
        for (int i = 0; i < `CFG_NREGS; i++) begin
            shadow[i] = 32'd0;
        end

        test_name = "reset";
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        check_value("pc after reset", `CFG_RESET_PC, pc);
        check_value("valid after reset", 32'd0, 32'(id_ex.valid));
        check_value("ctrl after reset", 32'd0, 32'(id_ex.ctrl));
        armed = 1'b1;
        repeat (3) drive_cycle(1'b0, 32'd0, 1'b0, 5'd0, 32'd0);

        test_name = "alu";
        for (int n = 0; n < N_ALU; n++) begin
            r    = rand_word();
            word = rand_inst(r[0] ? OPC_OP : OPC_OP_IMM);
            drive_cycle(1'b1, word, r[1], r[6:2], rand_word());
        end

        test_name = "regfile";
        write_reg(5'd5, 32'hcafe_0005);
        issue_inst({7'h00, 5'd0, 5'd5, 3'd0, 5'd1, OPC_OP});
        drive_cycle(1'b1, {7'h00, 5'd6, 5'd6, 3'd0, 5'd2, OPC_OP}, 1'b1, 5'd6, 32'h1234_5678);
        issue_inst({7'h20, 5'd6, 5'd5, 3'd7, 5'd3, OPC_OP});
        write_reg(5'd0, 32'hdead_beef);
        drive_cycle(1'b1, {12'h001, 5'd0, 3'd0, 5'd4, OPC_OP_IMM}, 1'b1, 5'd0, 32'h5555_aaaa);

        test_name = "branch";
        for (int c = 0; c < 6; c++) begin
            for (int p = 0; p < 3; p++) begin
                r = rand_word();
                write_reg(5'd1, pair_a[p]);
                write_reg(5'd2, pair_b[p]);
                issue_inst(branch_inst({r[12:1], 1'b0}, 5'd2, 5'd1, conds[c]));
            end
        end

        test_name = "jal";
        for (int n = 0; n < N_JUMP; n++) begin
            issue_inst(rand_inst(OPC_JAL));
        end

        test_name = "jalr";
        for (int n = 0; n < N_JUMP; n++) begin
            word = rand_inst(OPC_JALR);
            drive_cycle(1'b1, word, 1'b1, word[19:15], rand_word());
        end

        test_name = "random stream";
        for (int n = 0; n < N_RAND; n++) begin
            r    = rand_word();
            word = rand_inst(stream_opcode(r[2:0]));
            drive_cycle(r[3] | r[4], word, r[5], r[10:6], rand_word());
        end

        test_name = "drain";
        drive_cycle(1'b0, 32'd0, 1'b0, 5'd0, 32'd0);
        @(posedge clk);
        #5;
        $display("Simulation passed");
        $finish;
    end

endmodule

//--- flist.f
+incdir+include
hdl/core_pkg.sv
hdl/pc_gen.sv
hdl/regfile.sv
hdl/control_unit.sv
hdl/imm_gen.sv
hdl/id.sv
hdl/id_ex.sv
hdl/decode_top.sv
tb/tb_decode_top.sv

//--- Makefile
# Verilator build and run of the decode stage testbench

VERILATOR ?= verilator
TOP       ?= tb_decode_top
RTL_TOP   ?= decode_top
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# the run passes only if the pass message shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Simulation passed"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FLIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)
